/* design/soc_pkg.sv */
// Shared bus types and the address map of the SoC.
// Regions are chosen by address bits 31:28. Only the low four
// address bits select a DMA register.

`default_nettype none

package soc_pkg;

  ////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////

  parameter int DATA_W = 32;
  parameter int ADDR_W = 32;
  parameter int STRB_W = DATA_W / 8;

  // Scan code carried by the keyboard
  parameter int KEY_CODE_W = 8;

  // One bus request, held by the master until ack
  typedef struct packed {
    logic              cyc;
    logic              we;
    logic [STRB_W-1:0] strb;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } wb_req_t;

  // One bus response, ack lasts a single cycle
  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] rdata;
  } wb_rsp_t;

  ////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////

  parameter logic [3:0] REGION_MEM = 4'd0;
  parameter logic [3:0] REGION_KEY = 4'd1;
  parameter logic [3:0] REGION_DMA = 4'd2;

  // DMA register byte offsets
  parameter logic [3:0] DMA_SRC_OFS  = 4'h0;
  parameter logic [3:0] DMA_DST_OFS  = 4'h4;
  parameter logic [3:0] DMA_LEN_OFS  = 4'h8;
  parameter logic [3:0] DMA_CTRL_OFS = 4'hC;

endpackage

`default_nettype wire

/* design/wb_arbiter.sv */
// Round-robin arbiter for the host and DMA masters.
// A grant is held until the slave acks and is dropped the cycle after,
// so the bus sees one idle cycle between transfers.

`timescale 1ns/1ps
`default_nettype none

module wb_arbiter import soc_pkg::*; (
  input  wire     clk,
  input  wire     rst_n_i,
  input  wb_req_t host_req_i,
  input  wb_req_t dma_req_i,
  output wb_rsp_t host_rsp_o,
  output wb_rsp_t dma_rsp_o,
  output wb_req_t bus_req_o,
  input  wb_rsp_t bus_rsp_i
);

  typedef enum logic [1:0] {GNT_IDLE, GNT_HOST, GNT_DMA} grant_e;

  grant_e grant_q;
  // Set when the DMA won the last grant
  logic   dma_last_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      grant_q    <= GNT_IDLE;
      dma_last_q <= 1'b1;
    end else if (grant_q == GNT_IDLE) begin
      if (host_req_i.cyc && (!dma_req_i.cyc || dma_last_q)) begin
        grant_q    <= GNT_HOST;
        dma_last_q <= 1'b0;
      end else if (dma_req_i.cyc) begin
        grant_q    <= GNT_DMA;
        dma_last_q <= 1'b1;
      end
    end else if (bus_rsp_i.ack) begin
      grant_q <= GNT_IDLE;
    end
  end

  always_comb begin
    case (grant_q)
      GNT_HOST: bus_req_o = host_req_i;
      GNT_DMA:  bus_req_o = dma_req_i;
      default:  bus_req_o = '0;
    endcase
  end

  // The losing master sees no ack and keeps waiting
  assign host_rsp_o = '{ack: bus_rsp_i.ack && (grant_q == GNT_HOST), rdata: bus_rsp_i.rdata};
  assign dma_rsp_o  = '{ack: bus_rsp_i.ack && (grant_q == GNT_DMA), rdata: bus_rsp_i.rdata};

  // A granted master keeps cyc up until its ack
  a_cyc_granted: assert property (@(posedge clk) disable iff (!rst_n_i)
    (grant_q != GNT_IDLE) |-> bus_req_o.cyc)
    else $error("granted master dropped cyc before its ack");

endmodule

`default_nettype wire

/* design/wb_decoder.sv */
// Address decoder for three slaves selected by address bits 31:28.
// Regions 3 and above are unmapped; they are acked here one cycle
// later with zero read data and writes are dropped.

`timescale 1ns/1ps
`default_nettype none

module wb_decoder import soc_pkg::*; (
  input  wire     clk,
  input  wire     rst_n_i,
  input  wb_req_t bus_req_i,
  output wb_rsp_t bus_rsp_o,
  output wb_req_t mem_req_o,
  input  wb_rsp_t mem_rsp_i,
  output wb_req_t key_req_o,
  input  wb_rsp_t key_rsp_i,
  output wb_req_t dma_req_o,
  input  wb_rsp_t dma_rsp_i
);

  logic [3:0] region;
  logic       unmapped;
  logic       unm_ack_q;

  assign region   = bus_req_i.addr[31:28];
  assign unmapped = (region != REGION_MEM) && (region != REGION_KEY) && (region != REGION_DMA);

  // Same fields to every slave, cyc only to the selected one
  always_comb begin
    mem_req_o     = bus_req_i;
    key_req_o     = bus_req_i;
    dma_req_o     = bus_req_i;
    mem_req_o.cyc = bus_req_i.cyc && (region == REGION_MEM);
    key_req_o.cyc = bus_req_i.cyc && (region == REGION_KEY);
    dma_req_o.cyc = bus_req_i.cyc && (region == REGION_DMA);
  end

  // Default responder for holes in the map
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      unm_ack_q <= 1'b0;
    end else begin
      unm_ack_q <= bus_req_i.cyc && unmapped && !unm_ack_q;
    end
  end

  always_comb begin
    case (region)
      REGION_MEM: bus_rsp_o = mem_rsp_i;
      REGION_KEY: bus_rsp_o = key_rsp_i;
      REGION_DMA: bus_rsp_o = dma_rsp_i;
      default:    bus_rsp_o = '{ack: unm_ack_q, rdata: '0};
    endcase
  end

  // One slave selected and one slave answering at a time
  a_one_slave: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({mem_req_o.cyc, key_req_o.cyc, dma_req_o.cyc}) &&
    $onehot0({mem_rsp_i.ack, key_rsp_i.ack, dma_rsp_i.ack, unm_ack_q}))
    else $error("more than one slave active");

endmodule

`default_nettype wire

/* design/main_mem.sv */
// Word memory of 2**MEM_AW words with byte-lane strobes.
// Address bits above the word index are ignored, so the array aliases.
// Contents are not cleared by reset.

`timescale 1ns/1ps
`default_nettype none

module main_mem import soc_pkg::*; #(
  parameter int MEM_AW = 10
) (
  input  wire     clk,
  input  wire     rst_n_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  localparam int DEPTH = 2 ** MEM_AW;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [MEM_AW-1:0] word_idx;
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;
  logic              take;

  assign word_idx = req_i.addr[MEM_AW+1:2];
  // Accept once per request; the ack cycle itself is skipped
  assign take     = req_i.cyc && !ack_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rdata_q <= mem[word_idx];
      if (req_i.we) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (req_i.strb[b]) mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  assign rsp_o = '{ack: ack_q, rdata: rdata_q};

  // Master holds the same request from acceptance until ack
  a_ack_after_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_o.ack |-> req_i.cyc && $stable(req_i))
    else $error("memory request changed or dropped before its ack");

endmodule

`default_nettype wire

/* design/keyboard.sv */
// Keyboard register holding one scan code.
// A bus read returns {valid, code} and empties the buffer; writes are
// acked and have no effect. While full, key_ack_o stays low.

`timescale 1ns/1ps
`default_nettype none

module keyboard import soc_pkg::*; (
  input  wire                  clk,
  input  wire                  rst_n_i,
  input  wb_req_t              req_i,
  output wb_rsp_t              rsp_o,
  input  wire                  key_req_i,
  input  wire [KEY_CODE_W-1:0] key_code_i,
  output logic                 key_ack_o
);

  logic [KEY_CODE_W-1:0] code_q;
  logic                  valid_q;
  logic                  ack_q;
  logic [DATA_W-1:0]     rdata_q;
  logic                  bus_take;

  assign bus_take = req_i.cyc && !ack_q;

  ////////////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (bus_take) rdata_q <= {{(DATA_W-KEY_CODE_W-1){1'b0}}, valid_q, code_q};
  end

  ////////////////////////////////////////////////////////////////////
  // Four-phase device side and buffer state
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      valid_q   <= 1'b0;
      key_ack_o <= 1'b0;
      code_q    <= '0;
    end else begin
      ack_q <= bus_take;
      if (bus_take && !req_i.we) valid_q <= 1'b0;
      // New code only into an empty buffer, so it wins over the read
      if (key_req_i && !valid_q && !key_ack_o) begin
        code_q    <= key_code_i;
        valid_q   <= 1'b1;
        key_ack_o <= 1'b1;
      end else if (key_ack_o && !key_req_i) begin
        key_ack_o <= 1'b0;
      end
    end
  end

  assign rsp_o = '{ack: ack_q, rdata: rdata_q};

  a_key_ack_rise: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(key_ack_o) |-> key_req_i && $past(key_req_i))
    else $error("key_ack_o rose without a device request");

endmodule

`default_nettype wire

/* design/dma_engine.sv */
// DMA copy engine with SRC, DST, LEN and CTRL registers.
// Register writes take the whole word and are ignored while busy.
// Copies whole words; addresses step by 4. irq_o and the done bit
// stay set until irq_clear_i.

`timescale 1ns/1ps
`default_nettype none

module dma_engine import soc_pkg::*; (
  input  wire     clk,
  input  wire     rst_n_i,
  input  wb_req_t slv_req_i,
  output wb_rsp_t slv_rsp_o,
  output wb_req_t mst_req_o,
  input  wb_rsp_t mst_rsp_i,
  output logic    irq_o,
  input  wire     irq_clear_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_RD, ST_WR} state_e;

  state_e            state_q;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [DATA_W-1:0] len_q;
  logic [DATA_W-1:0] buf_q;
  logic [DATA_W-1:0] srdata_q;
  logic              done_q;
  logic              sack_q;
  logic              busy;
  logic              slv_take;

  assign busy     = (state_q != ST_IDLE);
  assign slv_take = slv_req_i.cyc && !sack_q;

  ////////////////////////////////////////////////////////////////////
  // Register port
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (slv_take) begin
      case (slv_req_i.addr[3:0])
        DMA_SRC_OFS:  srdata_q <= src_q;
        DMA_DST_OFS:  srdata_q <= dst_q;
        DMA_LEN_OFS:  srdata_q <= len_q;
        DMA_CTRL_OFS: srdata_q <= {{(DATA_W-2){1'b0}}, done_q, busy};
        default:      srdata_q <= '0;
      endcase
    end
    if (state_q == ST_RD && mst_rsp_i.ack) buf_q <= mst_rsp_i.rdata;
  end

  assign slv_rsp_o = '{ack: sack_q, rdata: srdata_q};

  ////////////////////////////////////////////////////////////////////
  // Copy FSM
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      sack_q  <= 1'b0;
      done_q  <= 1'b0;
      irq_o   <= 1'b0;
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
    end else begin
      sack_q <= slv_take;
      if (irq_clear_i) begin
        irq_o  <= 1'b0;
        done_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (slv_take && slv_req_i.we) begin
            case (slv_req_i.addr[3:0])
              DMA_SRC_OFS: src_q <= slv_req_i.wdata;
              DMA_DST_OFS: dst_q <= slv_req_i.wdata;
              DMA_LEN_OFS: len_q <= slv_req_i.wdata;
              DMA_CTRL_OFS: begin
                if (slv_req_i.wdata[0]) begin
                  done_q <= 1'b0;
                  // Empty copy finishes on the spot
                  if (len_q == '0) begin
                    done_q <= 1'b1;
                    irq_o  <= 1'b1;
                  end else begin
                    state_q <= ST_RD;
                  end
                end
              end
              default: ;
            endcase
          end
        end
        ST_RD: begin
          if (mst_rsp_i.ack) state_q <= ST_WR;
        end
        ST_WR: begin
          if (mst_rsp_i.ack) begin
            src_q <= src_q + 4;
            dst_q <= dst_q + 4;
            len_q <= len_q - 1'b1;
            if (len_q == 1) begin
              state_q <= ST_IDLE;
              done_q  <= 1'b1;
              irq_o   <= 1'b1;
            end else begin
              state_q <= ST_RD;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Master port follows the FSM state directly
  always_comb begin
    mst_req_o       = '0;
    mst_req_o.cyc   = busy;
    mst_req_o.we    = (state_q == ST_WR);
    mst_req_o.strb  = '1;
    mst_req_o.addr  = (state_q == ST_WR) ? dst_q : src_q;
    mst_req_o.wdata = buf_q;
  end

endmodule

`default_nettype wire

/* design/soc_top.sv */
// SoC bus fabric with an external host master and the DMA master.
// An idle-bus host access is acked 2 cycles after cyc rises.

`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; #(
  parameter int MEM_AW = 10
) (
  input  wire                  clk,
  input  wire                  rst_n_i,
  input  wb_req_t              host_req_i,
  output wb_rsp_t              host_rsp_o,
  input  wire                  key_req_i,
  input  wire [KEY_CODE_W-1:0] key_code_i,
  output logic                 key_ack_o,
  output logic                 irq_o,
  input  wire                  irq_clear_i
);

  wb_req_t dma_mst_req, bus_req, mem_req, key_req, dma_slv_req;
  wb_rsp_t dma_mst_rsp, bus_rsp, mem_rsp, key_rsp, dma_slv_rsp;

  wb_arbiter u_wb_arbiter (
    .clk, .rst_n_i, .host_req_i, .host_rsp_o,
    .dma_req_i (dma_mst_req), .dma_rsp_o (dma_mst_rsp),
    .bus_req_o (bus_req),     .bus_rsp_i (bus_rsp)
  );

  wb_decoder u_wb_decoder (
    .clk, .rst_n_i,
    .bus_req_i (bus_req),     .bus_rsp_o (bus_rsp),
    .mem_req_o (mem_req),     .mem_rsp_i (mem_rsp),
    .key_req_o (key_req),     .key_rsp_i (key_rsp),
    .dma_req_o (dma_slv_req), .dma_rsp_i (dma_slv_rsp)
  );

  main_mem #(.MEM_AW(MEM_AW)) u_main_mem (.clk, .rst_n_i, .req_i(mem_req), .rsp_o(mem_rsp));

  keyboard u_keyboard (
    .clk, .rst_n_i, .req_i(key_req), .rsp_o(key_rsp), .key_req_i, .key_code_i, .key_ack_o
  );

  dma_engine u_dma_engine (
    .clk, .rst_n_i,
    .slv_req_i (dma_slv_req), .slv_rsp_o (dma_slv_rsp),
    .mst_req_o (dma_mst_req), .mst_rsp_i (dma_mst_rsp),
    .irq_o, .irq_clear_i
  );

endmodule

`default_nettype wire

/* bench/soc_tb.sv */
// Testbench for soc_top. Commands come from bench/soc_tests.txt, which is
// read from the project root. Each line is an op letter and three hex fields.
// A reference model covers written memory words only, so read only words
// that were written. DMA source and destination ranges must not overlap.

`timescale 1ns/1ps
`default_nettype none

module soc_tb import soc_pkg::*; ();

  localparam int MEM_AW         = 10;
  localparam int CYCLES_PER_CMD = 400;
  localparam int KEY_WAIT       = 20;

  logic                  clk;
  logic                  rst_n;
  wb_req_t               host_req;
  wb_rsp_t               host_rsp;
  logic                  key_req;
  logic [KEY_CODE_W-1:0] key_code;
  logic                  key_ack;
  logic                  irq;
  logic                  irq_clear;

  // Commands as loaded from the data file
  logic [7:0]  op_q [$];
  logic [31:0] f1_q [$];
  logic [31:0] f2_q [$];
  logic [31:0] f3_q [$];
  int          n_cmds;
  logic        loaded;
  int          errors;

  // Expected memory contents, keyed by aliased word index
  logic [31:0] mem_model [int];

  soc_top #(.MEM_AW(MEM_AW)) uut (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .host_req_i  (host_req),
    .host_rsp_o  (host_rsp),
    .key_req_i   (key_req),
    .key_code_i  (key_code),
    .key_ack_o   (key_ack),
    .irq_o       (irq),
    .irq_clear_i (irq_clear)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checking and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // Higher address bits are ignored by the memory
  function automatic int word_key(input logic [31:0] addr);
    return int'((addr >> 2) & ((32'd1 << MEM_AW) - 32'd1));
  endfunction

  function automatic logic [31:0] dma_reg(input logic [3:0] ofs);
    return {REGION_DMA, 24'h0, ofs};
  endfunction

  task automatic wait_drive_slot();
    @(posedge clk);
    #2;
  endtask

  // One host transfer, held until the fabric acks
  task automatic bus_access(input logic write_en, input logic [31:0] addr,
                            input logic [3:0] strb, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    wait_drive_slot();
    host_req = '{cyc: 1'b1, we: write_en, strb: strb, addr: addr, wdata: wdata};
    do @(negedge clk); while (!host_rsp.ack);
    rdata = host_rsp.rdata;
    wait_drive_slot();
    host_req = '0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] data);
    logic [31:0] unused_rd;
    bus_access(1'b1, addr, strb, data, unused_rd);
  endtask

  task automatic mem_write(input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] data);
    int          k;
    logic [31:0] word;
    bus_write(addr, strb, data);
    k = word_key(addr);
    if (addr[31:28] == REGION_MEM) begin
      word = mem_model.exists(k) ? mem_model[k] : 32'h0;
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
      end
      mem_model[k] = word;
    end
  endtask

  task automatic read_and_check(input logic [31:0] addr, input logic [31:0] expected);
    logic [31:0] rd;
    int          k;
    bus_access(1'b0, addr, 4'h0, 32'h0, rd);
    check_value(rd, expected, $sformatf("read at %h", addr));
    k = word_key(addr);
    if (addr[31:28] == REGION_MEM && mem_model.exists(k)) begin
      check_value(rd, mem_model[k], $sformatf("memory model at %h", addr));
    end
  endtask

  // Four-phase press; a refused press keeps key_req high
  task automatic key_press(input logic [7:0] code, input logic expect_accept);
    logic accepted;
    wait_drive_slot();
    key_code = code;
    key_req  = 1'b1;
    accepted = 1'b0;
    for (int i = 0; i < KEY_WAIT && !accepted; i++) begin
      @(negedge clk);
      accepted = key_ack;
    end
    check_value({31'b0, accepted}, {31'b0, expect_accept}, "keyboard accept");
    if (accepted) begin
      wait_drive_slot();
      key_req = 1'b0;
      do @(negedge clk); while (key_ack);
    end
  endtask

  task automatic dma_copy(input logic [31:0] src, input logic [31:0] dst,
                          input logic [31:0] len);
    logic [31:0] rd;
    logic [31:0] src_addr;
    int          polls;
    int          n;
    n = int'(len);
    polls = 0;
    bus_write(dma_reg(DMA_SRC_OFS), 4'hF, src);
    bus_write(dma_reg(DMA_DST_OFS), 4'hF, dst);
    bus_write(dma_reg(DMA_LEN_OFS), 4'hF, len);
    bus_write(dma_reg(DMA_CTRL_OFS), 4'hF, 32'h1);
    while (!irq) begin
      bus_access(1'b0, dma_reg(DMA_CTRL_OFS), 4'h0, 32'h0, rd);
      if (!irq) begin
        check_value(rd, 32'h1, "DMA CTRL while copying");
        polls++;
      end
      // Host reads of source words share the bus with the copy
      if (n > 0) begin
        src_addr = src + 32'(4 * (polls % n));
        read_and_check(src_addr, mem_model[word_key(src_addr)]);
      end
    end
    if (n >= 2) check_value({31'b0, polls > 0}, 32'h1, "DMA busy seen before irq");
    read_and_check(dma_reg(DMA_CTRL_OFS), 32'h2);
    for (int i = 0; i < n; i++) begin
      mem_model[word_key(dst + 32'(4 * i))] = mem_model[word_key(src + 32'(4 * i))];
      read_and_check(dst + 32'(4 * i), mem_model[word_key(src + 32'(4 * i))]);
    end
  endtask

  task automatic irq_clear_pulse();
    wait_drive_slot();
    irq_clear = 1'b1;
    wait_drive_slot();
    irq_clear = 1'b0;
    check_value({31'b0, irq}, 32'h0, "irq after clear");
    read_and_check(dma_reg(DMA_CTRL_OFS), 32'h0);
  endtask

  task automatic load_tests();
    int                 fd;
    int                 r;
    logic [7:0]         op_tok;
    logic [8*128-1:0]   skip_line;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        c;
    fd = $fopen("bench/soc_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file bench/soc_tests.txt");
      $display("TESTS FAILED");
      $fatal(1, "no test file");
    end else begin
      while (!$feof(fd)) begin
        op_tok = 8'h0;
        r = $fscanf(fd, "%s", op_tok);
        if (r == 1) begin
          if (op_tok == "#") begin
            r = $fgets(skip_line, fd);
          end else begin
            r = $fscanf(fd, "%h %h %h", a, b, c);
            op_q.push_back(op_tok);
            f1_q.push_back(a);
            f2_q.push_back(b);
            f3_q.push_back(c);
          end
        end
      end
      $fclose(fd);
      n_cmds = op_q.size();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    host_req  = '0;
    key_req   = 1'b0;
    key_code  = '0;
    irq_clear = 1'b0;
    rst_n     = 1'b0;
    errors    = 0;
    loaded    = 1'b0;
    void'($urandom(32'he1322b10));
    load_tests();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value({31'b0, host_rsp.ack}, 32'h0, "host ack after reset");
    check_value({31'b0, key_ack}, 32'h0, "key ack after reset");
    check_value({31'b0, irq}, 32'h0, "irq after reset");
    for (int i = 0; i < n_cmds; i++) begin
      repeat (int'($urandom_range(3, 0))) @(posedge clk);
      case (op_q[i])
        "W": mem_write(f1_q[i], f2_q[i][3:0], f3_q[i]);
        "R": read_and_check(f1_q[i], f2_q[i]);
        "K": key_press(f1_q[i][7:0], f2_q[i][0]);
        "D": dma_copy(f1_q[i], f2_q[i], f3_q[i]);
        "I": irq_clear_pulse();
        default: begin
          $display("Unknown command in the test file at entry %0d", i);
          $display("TESTS FAILED");
          $fatal(1, "bad command");
        end
      endcase
    end
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (n_cmds * CYCLES_PER_CMD + 100) @(posedge clk);
    $display("Timeout: the tests did not finish in %0d clock cycles",
             n_cmds * CYCLES_PER_CMD + 100);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* bench/soc_tests.txt */
# op f1 f2 f3 (hex): W addr strb data, R addr expect 0, K code accept 0
# D src dst len, I 0 0 0 (clear irq)
R 2000000C 00000000 0
W 00000010 F 11223344
R 00000010 11223344 0
W 00000010 3 0000AABB
W 00000010 8 CC000000
R 00000010 CC22AABB 0
R 00001010 CC22AABB 0
W 00000100 F 0A0B0C0D
W 00000104 F 1A1B1C1D
W 00000108 F 2A2B2C2D
W 0000010C F 3A3B3C3D
D 00000100 00000200 4
R 00000204 1A1B1C1D 0
I 0 0 0
D 00000100 00000300 0
I 0 0 0
K 41 1 0
R 10000000 00000141 0
R 10000000 00000041 0
K 52 1 0
K 63 0 0
R 10000000 00000152 0
K 63 1 0
R 10000000 00000163 0
R 30000000 00000000 0
R F0000010 00000000 0

/* soc.f */
design/soc_pkg.sv
design/wb_arbiter.sv
design/wb_decoder.sv
design/main_mem.sv
design/keyboard.sv
design/dma_engine.sv
design/soc_top.sv
bench/soc_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the SoC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module soc_tb -f soc.f -o soc_sim
./obj_dir/soc_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
